//--- all.f
src/commit_pkg.sv
src/wb_stage.sv
src/commit_ctrl.sv
src/csr_file.sv
src/reg_file.sv
src/commit_top.sv
bench/commit_tb.sv

//--- Bender.yml
package:
  name: commit_wb

sources:
  - src/commit_pkg.sv
  - src/wb_stage.sv
  - src/commit_ctrl.sv
  - src/csr_file.sv
  - src/reg_file.sv
  - src/commit_top.sv
  - target: test
    files:
      - bench/commit_tb.sv

//--- bench/commit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module commit_tb;

    import commit_pkg::*;

    localparam word_t TB_EENTRY = 32'h1c00_1000;
    localparam int    N_CYCLES  = 3000;

    logic        clk = 1'b0;
    logic        resetn;
    logic        mem_valid;
    mem_wb_bus_t mem_bus;
    reg_addr_t   rd_addr1;
    reg_addr_t   rd_addr2;
    word_t       rd_data1;
    word_t       rd_data2;
    flush_t      flush;
    trace_t      trace;
    logic [1:0]  cur_plv;
    logic        cur_ie;

    word_t       m_regs [32];
    word_t       m_csr [64];    // indexed by csr number up to 0x3f
    logic        m_valid;       // model of the WB stage
    mem_wb_bus_t m_bus;
    logic        drv_valid;     // last strobe driven
    mem_wb_bus_t drv_bus;
    logic        exp_ex;
    ecode_t      exp_ecode;
    flush_t      exp_flush;
    trace_t      exp_trace;

    commit_top #(.EENTRY_RESET(TB_EENTRY)) DUT (
        .clk       (clk),
        .resetn    (resetn),
        .mem_valid (mem_valid),
        .mem_bus   (mem_bus),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .flush     (flush),
        .trace     (trace),
        .cur_plv   (cur_plv),
        .cur_ie    (cur_ie)
    );

    always #10 clk = ~clk;

    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
    end

    task automatic fail_and_stop();
        $display("** FAIL **");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_flush(input flush_t got, input flush_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target)) begin
            $display("Fail flush: got %h, expected %h", got, exp);
            fail_and_stop();
        end
    endtask

    // only the write enable matters when nothing is written
    task automatic check_trace(input trace_t got, input trace_t exp);
        if (got.we !== exp.we || (exp.we && got !== exp)) begin
            $display("Fail trace: got %h, expected %h", got, exp);
            fail_and_stop();
        end
    endtask

    function automatic word_t writable_bits(input csr_num_t num);
        case (num)
            CSR_CRMD, CSR_PRMD: return 32'h7;
            CSR_ESTAT:          return 32'h3;
            CSR_EENTRY:         return 32'hffff_ffc0;
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return '1;
            default:            return '0;
        endcase
    endfunction

    function automatic ecode_t exception_code(input excp_t e);
        if (e.int_) return ECODE_INT;
        if (e.adef) return ECODE_ADEF;
        if (e.syscall) return ECODE_SYS;
        if (e.brk) return ECODE_BRK;
        if (e.ine) return ECODE_INE;
        return ECODE_ALE;
    endfunction

    function automatic word_t expected_read(input reg_addr_t addr);
        if (addr == '0) return '0;
        if (exp_trace.we && exp_trace.wnum == addr) return exp_trace.wdata;
        return m_regs[addr];
    endfunction

    function automatic csr_num_t pick_csr();
        case ($urandom_range(0, 10))
            0: return CSR_CRMD;
            1: return CSR_PRMD;
            2: return CSR_ESTAT;
            3: return CSR_ERA;
            4: return CSR_BADV;
            5: return CSR_EENTRY;
            6: return CSR_SAVE0;
            7: return CSR_SAVE1;
            8: return CSR_SAVE2;
            9: return CSR_SAVE3;
            default: return 14'h2;   // not implemented
        endcase
    endfunction

    task automatic random_bundle(output logic v, output mem_wb_bus_t b);
        logic [5:0] flags;
        b            = '0;
        v            = ($urandom_range(0, 3) != 0);
        b.pc         = $urandom & 32'hffff_fffc;
        b.rf_we      = $urandom_range(0, 1);
        b.rf_waddr   = 5'($urandom_range(0, 31));
        b.result     = $urandom;
        b.csr_re     = ($urandom_range(0, 2) == 0);
        b.csr_we     = ($urandom_range(0, 2) == 0);
        b.csr_num    = pick_csr();
        b.csr_wmask  = ($urandom_range(0, 1) == 1) ? '1 : $urandom;
        b.csr_wvalue = $urandom;
        b.esubcode   = 9'($urandom_range(0, 511));
        b.vaddr      = $urandom;
        flags        = 6'($urandom_range(1, 63));
        if ($urandom_range(0, 9) == 0) begin
            b.excp = flags;
            b.ertn = $urandom_range(0, 1);   // exception must still win
        end else if ($urandom_range(0, 18) == 0) begin
            b.ertn   = 1'b1;   // plain ertn without writes
            b.csr_we = 1'b0;
            b.rf_we  = 1'b0;
        end
    endtask

    // state update at the edge that ends the WB cycle
    task automatic commit_model();
        word_t wm;
        if (exp_trace.we && exp_trace.wnum != '0) m_regs[exp_trace.wnum] = exp_trace.wdata;
        if (m_valid && m_bus.csr_we && !exp_ex && m_bus.csr_num < 64) begin
            wm = m_bus.csr_wmask & writable_bits(m_bus.csr_num);
            m_csr[m_bus.csr_num] = (m_csr[m_bus.csr_num] & ~wm) | (m_bus.csr_wvalue & wm);
        end
        if (exp_ex) begin
            m_csr[CSR_PRMD][2:0]    = m_csr[CSR_CRMD][2:0];
            m_csr[CSR_CRMD][2:0]    = 3'b0;
            m_csr[CSR_ERA]          = m_bus.pc;
            m_csr[CSR_ESTAT][21:16] = exp_ecode;
            m_csr[CSR_ESTAT][30:22] = m_bus.esubcode;
            if (exp_ecode == ECODE_ADEF) m_csr[CSR_BADV] = m_bus.pc;
            else if (exp_ecode == ECODE_ALE) m_csr[CSR_BADV] = m_bus.vaddr;
        end else if (exp_flush.valid) begin
            m_csr[CSR_CRMD][2:0] = m_csr[CSR_PRMD][2:0];   // ertn
        end
    endtask

    task automatic predict_and_check();
        word_t old_csr;
        logic  is_ertn;
        exp_ex           = m_valid && (|m_bus.excp);
        is_ertn          = m_valid && m_bus.ertn && !exp_ex;
        exp_ecode        = exception_code(m_bus.excp);
        old_csr          = (m_bus.csr_num < 64) ? m_csr[m_bus.csr_num] : '0;
        exp_trace.pc     = m_bus.pc;
        exp_trace.we     = m_valid && m_bus.rf_we && !exp_ex;
        exp_trace.wnum   = m_bus.rf_waddr;
        exp_trace.wdata  = m_bus.csr_re ? old_csr : m_bus.result;
        exp_flush.valid  = exp_ex || is_ertn;
        exp_flush.target = exp_ex ? m_csr[CSR_EENTRY] : m_csr[CSR_ERA];
        check_flush(flush, exp_flush);
        check_trace(trace, exp_trace);
        check_word("rd_data1", rd_data1, expected_read(rd_addr1));
        check_word("rd_data2", rd_data2, expected_read(rd_addr2));
        check_word("crmd", {29'b0, cur_ie, cur_plv}, m_csr[CSR_CRMD]);
    endtask

    initial begin
        int          wait_cycles;
        logic        v;
        mem_wb_bus_t b;
        void'($urandom(32'h0647_74c6));
        mem_valid = 1'b0;
        mem_bus   = '0;
        rd_addr1  = '0;
        rd_addr2  = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_csr[i]) m_csr[i] = '0;
        m_csr[CSR_EENTRY] = TB_EENTRY;
        m_valid   = 1'b0;
        m_bus     = '0;
        drv_valid = 1'b0;
        drv_bus   = '0;
        exp_ex    = 1'b0;
        exp_ecode = '0;
        exp_flush = '0;
        exp_trace = '0;
        wait_cycles = 0;
        while (resetn !== 1'b1) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 50) begin
                $display("reset was not released within 50 cycles");
                fail_and_stop();
            end
        end
        for (int i = 0; i < N_CYCLES; i++) begin
            commit_model();
            if (drv_valid) m_bus = drv_bus;
            m_valid = drv_valid && !exp_flush.valid;   // strobe at a flush edge is lost
            random_bundle(v, b);
            if (i == 0) begin
                v          = 1'b1;   // first one reads EENTRY into r1
                b.excp     = '0;
                b.ertn     = 1'b0;
                b.csr_re   = 1'b1;
                b.csr_we   = 1'b0;
                b.csr_num  = CSR_EENTRY;
                b.rf_we    = 1'b1;
                b.rf_waddr = 5'd1;
            end
            mem_valid <= v;
            mem_bus   <= b;
            rd_addr1  <= ($urandom_range(0, 1) == 1) ? m_bus.rf_waddr : 5'($urandom_range(0, 31));
            rd_addr2  <= 5'($urandom_range(0, 31));
            drv_valid = v;
            drv_bus   = b;
            @(negedge clk);
            predict_and_check();
            @(posedge clk);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/commit_top.sv
`timescale 1ns/100ps
`default_nettype none

module commit_top #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c00_8000
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    mem_valid,
    input  commit_pkg::mem_wb_bus_t mem_bus,
    input  commit_pkg::reg_addr_t   rd_addr1,
    input  commit_pkg::reg_addr_t   rd_addr2,
    output commit_pkg::word_t       rd_data1,
    output commit_pkg::word_t       rd_data2,
    output commit_pkg::flush_t      flush,
    output commit_pkg::trace_t      trace,
    output logic [1:0]              cur_plv,
    output logic                    cur_ie
);

    import commit_pkg::*;

    logic        wb_valid;
    mem_wb_bus_t wb_bus;
    word_t       csr_rvalue;
    word_t       eentry;
    word_t       era;
    rf_write_t   rf_wr;
    csr_req_t    csr_req;
    csr_event_t  csr_evt;

    wb_stage u_wb_stage (
        .clk         (clk),
        .resetn      (resetn),
        .mem_valid   (mem_valid),
        .mem_bus     (mem_bus),
        .flush_valid (flush.valid),
        .wb_valid    (wb_valid),
        .wb_bus      (wb_bus)
    );

    commit_ctrl u_commit_ctrl (
        .wb_valid   (wb_valid),
        .wb_bus     (wb_bus),
        .csr_rvalue (csr_rvalue),
        .eentry     (eentry),
        .era        (era),
        .rf_wr      (rf_wr),
        .csr_req    (csr_req),
        .csr_evt    (csr_evt),
        .flush      (flush),
        .trace      (trace)
    );

    csr_file #(
        .EENTRY_RESET (EENTRY_RESET)
    ) u_csr_file (
        .clk    (clk),
        .resetn (resetn),
        .req    (csr_req),
        .evt    (csr_evt),
        .rvalue (csr_rvalue),
        .eentry (eentry),
        .era    (era),
        .plv    (cur_plv),
        .ie     (cur_ie)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .resetn (resetn),
        .wr     (rf_wr),
        .raddr1 (rd_addr1),
        .raddr2 (rd_addr2),
        .rdata1 (rd_data1),
        .rdata2 (rd_data2)
    );

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  resetn,
    input  commit_pkg::rf_write_t wr,
    input  commit_pkg::reg_addr_t raddr1,
    input  commit_pkg::reg_addr_t raddr2,
    output commit_pkg::word_t     rdata1,
    output commit_pkg::word_t     rdata2
);

    import commit_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;   // r0 stays zero
        end
    end

    // one read port, with write-through of the committing value
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr.we && wr.waddr == addr) begin
            return wr.wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
    end

    always_comb begin
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

//--- src/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c00_8000
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  commit_pkg::csr_req_t   req,
    input  commit_pkg::csr_event_t evt,
    output commit_pkg::word_t      rvalue,
    output commit_pkg::word_t      eentry,
    output commit_pkg::word_t      era,
    output logic [1:0]             plv,
    output logic                   ie
);

    import commit_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [1:0]  estat_is;       // software interrupt bits
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era_q;
    word_t       badv_q;
    logic [25:0] eentry_va;      // entry is 64-byte aligned
    word_t       save0;
    word_t       save1;
    word_t       save2;
    word_t       save3;
    word_t       wr_merged;

    always_comb begin
        case (req.num)
            CSR_CRMD:   rvalue = {29'b0, crmd_ie, crmd_plv};
            CSR_PRMD:   rvalue = {29'b0, prmd_pie, prmd_pplv};
            CSR_ESTAT:  rvalue = {1'b0, estat_esubcode, estat_ecode, 14'b0, estat_is};
            CSR_ERA:    rvalue = era_q;
            CSR_BADV:   rvalue = badv_q;
            CSR_EENTRY: rvalue = {eentry_va, 6'b0};
            CSR_SAVE0:  rvalue = save0;
            CSR_SAVE1:  rvalue = save1;
            CSR_SAVE2:  rvalue = save2;
            CSR_SAVE3:  rvalue = save3;
            default:    rvalue = '0;  // unimplemented
        endcase
    end

    // old value is the read of the same number
    assign wr_merged = (rvalue & ~req.wmask) | (req.wvalue & req.wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv       <= 2'b0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            estat_is       <= 2'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_q          <= '0;
            badv_q         <= '0;
            eentry_va      <= EENTRY_RESET[31:6];
            save0          <= '0;
            save1          <= '0;
            save2          <= '0;
            save3          <= '0;
        end else begin
            if (req.we) begin
                case (req.num)
                    CSR_CRMD:   {crmd_ie, crmd_plv} <= wr_merged[2:0];
                    CSR_PRMD:   {prmd_pie, prmd_pplv} <= wr_merged[2:0];
                    CSR_ESTAT:  estat_is <= wr_merged[1:0];
                    CSR_ERA:    era_q <= wr_merged;
                    CSR_BADV:   badv_q <= wr_merged;
                    CSR_EENTRY: eentry_va <= wr_merged[31:6];
                    CSR_SAVE0:  save0 <= wr_merged;
                    CSR_SAVE1:  save1 <= wr_merged;
                    CSR_SAVE2:  save2 <= wr_merged;
                    CSR_SAVE3:  save3 <= wr_merged;
                    default:    ;
                endcase
            end
            // events come last so they win over a csr write in the same cycle
            if (evt.ex) begin
                prmd_pplv      <= crmd_plv;
                prmd_pie       <= crmd_ie;
                crmd_plv       <= 2'b0;   // enter kernel, interrupts off
                crmd_ie        <= 1'b0;
                era_q          <= evt.pc;
                estat_ecode    <= evt.ecode;
                estat_esubcode <= evt.esubcode;
                if (evt.badv_we) begin
                    badv_q <= evt.vaddr;
                end
            end else if (evt.ertn) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end
        end
    end

    assign eentry = {eentry_va, 6'b0};
    assign era    = era_q;
    assign plv    = crmd_plv;
    assign ie     = crmd_ie;

endmodule

`default_nettype wire

//--- src/commit_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module commit_ctrl (
    input  logic                    wb_valid,
    input  commit_pkg::mem_wb_bus_t wb_bus,
    input  commit_pkg::word_t       csr_rvalue,
    input  commit_pkg::word_t       eentry,
    input  commit_pkg::word_t       era,
    output commit_pkg::rf_write_t   rf_wr,
    output commit_pkg::csr_req_t    csr_req,
    output commit_pkg::csr_event_t  csr_evt,
    output commit_pkg::flush_t      flush,
    output commit_pkg::trace_t      trace
);

    import commit_pkg::*;

    logic   wb_ex;
    logic   wb_ertn;
    ecode_t ecode;
    word_t  final_wdata;

    assign wb_ex   = wb_valid && (|wb_bus.excp);
    assign wb_ertn = wb_valid && wb_bus.ertn && !wb_ex;   // exception wins

    // highest priority first
    always_comb begin
        if (wb_bus.excp.int_) begin
            ecode = ECODE_INT;
        end else if (wb_bus.excp.adef) begin
            ecode = ECODE_ADEF;
        end else if (wb_bus.excp.syscall) begin
            ecode = ECODE_SYS;
        end else if (wb_bus.excp.brk) begin
            ecode = ECODE_BRK;
        end else if (wb_bus.excp.ine) begin
            ecode = ECODE_INE;
        end else begin
            ecode = ECODE_ALE;
        end
    end

    // csrrd/csrwr/csrxchg return the old csr value
    assign final_wdata = wb_bus.csr_re ? csr_rvalue : wb_bus.result;

    assign rf_wr.we    = wb_valid && wb_bus.rf_we && !wb_ex;
    assign rf_wr.waddr = wb_bus.rf_waddr;
    assign rf_wr.wdata = final_wdata;

    assign csr_req.num    = wb_bus.csr_num;   // read side is combinational
    assign csr_req.we     = wb_valid && wb_bus.csr_we && !wb_ex;
    assign csr_req.wmask  = wb_bus.csr_wmask;
    assign csr_req.wvalue = wb_bus.csr_wvalue;

    assign csr_evt.ex       = wb_ex;
    assign csr_evt.ertn     = wb_ertn;
    assign csr_evt.ecode    = ecode;
    assign csr_evt.esubcode = wb_bus.esubcode;
    assign csr_evt.pc       = wb_bus.pc;

    // badv only for address faults; fetch faults record the pc itself
    assign csr_evt.badv_we = wb_ex && (ecode == ECODE_ADEF || ecode == ECODE_ALE);
    assign csr_evt.vaddr   = (ecode == ECODE_ADEF) ? wb_bus.pc : wb_bus.vaddr;

    assign flush.valid  = wb_ex || wb_ertn;
    assign flush.target = wb_ex ? eentry : era;

    // debug trace
    assign trace.pc    = wb_bus.pc;
    assign trace.we    = rf_wr.we;
    assign trace.wnum  = wb_bus.rf_waddr;
    assign trace.wdata = final_wdata;

endmodule

`default_nettype wire

//--- src/wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    mem_valid,
    input  commit_pkg::mem_wb_bus_t mem_bus,
    input  logic                    flush_valid,
    output logic                    wb_valid,
    output commit_pkg::mem_wb_bus_t wb_bus
);

    // stage is always ready, so every strobe is accepted
    // an instruction sits in WB for exactly one cycle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush_valid) begin
            wb_valid <= 1'b0;   // younger bundle at the flush edge is dropped
        end else begin
            wb_valid <= mem_valid;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_bus <= mem_bus;
        end
    end

endmodule

`default_nettype wire

//--- src/commit_pkg.sv
`default_nettype none

package commit_pkg;

    typedef logic [31:0] word_t;      // data word or address
    typedef logic [4:0]  reg_addr_t;  // general register number
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    typedef struct packed {
        logic int_;
        logic adef;
        logic syscall;
        logic brk;
        logic ine;
        logic ale;
    } excp_t;

    // bundle latched from the memory stage
    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     result;
        logic      csr_re;
        logic      csr_we;
        csr_num_t  csr_num;
        word_t     csr_wmask;
        word_t     csr_wvalue;
        logic      ertn;
        excp_t     excp;
        esubcode_t esubcode;
        word_t     vaddr;      // faulting data address for ale
    } mem_wb_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        csr_num_t num;
        logic     we;
        word_t    wmask;
        word_t    wvalue;
    } csr_req_t;

    typedef struct packed {
        logic      ex;
        logic      ertn;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
        logic      badv_we;
        word_t     vaddr;
    } csr_event_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } flush_t;

    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;

    localparam ecode_t ECODE_INT  = 6'h0;
    localparam ecode_t ECODE_ADEF = 6'h8;
    localparam ecode_t ECODE_ALE  = 6'h9;
    localparam ecode_t ECODE_SYS  = 6'hb;
    localparam ecode_t ECODE_BRK  = 6'hc;
    localparam ecode_t ECODE_INE  = 6'hd;

endpackage

`default_nettype wire
